//--- eeprom_pkg.sv
package eeprom_pkg;

    // word address width of the 2 Kbyte part
    localparam int ADDR_W = 11;

    // device type code, upper nibble of the control byte
    localparam logic [3:0] DEV_CODE = 4'b1010;

    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } host_op_e;

    // one-hot sequencer states
    typedef enum logic [9:0] {
        S_IDLE    = 10'b00_0000_0001,
        S_START   = 10'b00_0000_0010,
        S_CTRL_WR = 10'b00_0000_0100,  // control byte, r/w bit clear
        S_ADDR    = 10'b00_0000_1000,
        S_DATA    = 10'b00_0001_0000,
        S_RESTART = 10'b00_0010_0000,
        S_CTRL_RD = 10'b00_0100_0000,  // control byte, r/w bit set
        S_READ    = 10'b00_1000_0000,
        S_STOP    = 10'b01_0000_0000,
        S_DONE    = 10'b10_0000_0000   // host handshake
    } seq_state_e;

endpackage

//--- serial_bus_pkg.sv
package serial_bus_pkg;

    // commands from the sequencer to the bit engine
    typedef enum logic [1:0] {
        CMD_START = 2'd0,  // also used for the repeated start
        CMD_STOP  = 2'd1,
        CMD_WRITE = 2'd2,  // byte out, slave ack in
        CMD_READ  = 2'd3   // byte in, master nack out
    } bus_cmd_e;

    typedef enum logic [2:0] {
        PH_IDLE      = 3'd0,
        PH_START     = 3'd1,
        PH_STOP      = 3'd2,
        PH_SHIFT_OUT = 3'd3,
        PH_ACK_IN    = 3'd4,
        PH_SHIFT_IN  = 3'd5,
        PH_ACK_OUT   = 3'd6,
        PH_DONE      = 3'd7
    } bit_phase_e;

endpackage

//--- byte_shift_if.sv
`timescale 1ns/1ps
interface byte_shift_if;
    import serial_bus_pkg::*;

    logic       req;      // four-phase request from the sequencer
    logic       ack;
    bus_cmd_e   cmd;
    logic [7:0] tx_byte;
    logic [7:0] rx_byte;  // valid after a read-byte command
    logic       nack;     // sampled ack bit, high when the slave did not ack

    modport master (
        output req, cmd, tx_byte,
        input  ack, rx_byte, nack
    );

    modport engine (
        input  req, cmd, tx_byte,
        output ack, rx_byte, nack
    );

endinterface

//--- bus_bit_engine.sv
`timescale 1ns/1ps
module bus_bit_engine #(
    parameter int CLK_DIV = 2
) (
    input  logic         CLK,
    input  logic         RESET,
    byte_shift_if.engine bus,
    output logic         SCL,
    input  logic         sda_in,
    output logic         sda_out_en
);
    import serial_bus_pkg::*;

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLK_DIV - 1);

    bit_phase_e       phase;
    logic [DIV_W-1:0] div_cnt;
    logic [1:0]       qtr;      // quarter within the current bit
    logic [2:0]       bit_cnt;
    logic [7:0]       shreg;
    logic             active;
    logic             tick;     // last cycle of a quarter
    logic             bit_end;
    logic             sample;
    logic             scl_hi;
    logic             scl_d;
    logic             oe_d;

    assign active  = (phase != PH_IDLE) && (phase != PH_DONE);
    assign tick    = active && (div_cnt == DIV_LAST);
    assign bit_end = tick && (qtr == 2'd3);
    assign sample  = tick && (qtr == 2'd1);  // middle of scl high
    assign scl_hi  = qtr[0] ^ qtr[1];        // high in q1 and q2

    assign bus.rx_byte = shreg;

    // line levels for the next cycle
    always_comb
    begin
        scl_d = SCL;
        oe_d  = sda_out_en;
        case (phase)
            PH_START:
            begin
                scl_d = scl_hi;
                oe_d  = qtr[1];        // sda falls in q2, scl high
            end
            PH_STOP:
            begin
                scl_d = (qtr != 2'd0);
                oe_d  = ~qtr[1];       // sda rises in q2, scl high
            end
            PH_SHIFT_OUT:
            begin
                scl_d = scl_hi;
                oe_d  = ~shreg[7];     // msb first
            end
            PH_ACK_IN, PH_SHIFT_IN, PH_ACK_OUT:
            begin
                scl_d = scl_hi;
                oe_d  = 1'b0;          // released, in ack out this is the nack
            end
            default: ;                 // lines hold between commands
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            phase      <= PH_IDLE;
            div_cnt    <= '0;
            qtr        <= 2'd0;
            bit_cnt    <= 3'd0;
            bus.ack    <= 1'b0;
            bus.nack   <= 1'b0;
            SCL        <= 1'b1;
            sda_out_en <= 1'b0;
        end
        else
        begin
            SCL        <= scl_d;
            sda_out_en <= oe_d;

            if (!active || tick)
                div_cnt <= '0;
            else
                div_cnt <= div_cnt + 1'b1;

            if (tick)
                qtr <= qtr + 2'd1;

            case (phase)
                PH_IDLE:
                    if (bus.req)
                    begin
                        qtr     <= 2'd0;
                        bit_cnt <= 3'd0;
                        case (bus.cmd)
                            CMD_START: phase <= PH_START;
                            CMD_STOP:  phase <= PH_STOP;
                            CMD_WRITE: phase <= PH_SHIFT_OUT;
                            default:   phase <= PH_SHIFT_IN;
                        endcase
                    end
                PH_START, PH_STOP, PH_ACK_OUT:
                    if (bit_end)
                    begin
                        phase   <= PH_DONE;
                        bus.ack <= 1'b1;
                    end
                PH_SHIFT_OUT:
                    if (bit_end)
                    begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            phase <= PH_ACK_IN;
                    end
                PH_ACK_IN:
                begin
                    if (sample)
                        bus.nack <= sda_in;
                    if (bit_end)
                    begin
                        phase   <= PH_DONE;
                        bus.ack <= 1'b1;
                    end
                end
                PH_SHIFT_IN:
                    if (bit_end)
                    begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            phase <= PH_ACK_OUT;
                    end
                PH_DONE:
                    if (!bus.req)
                    begin
                        bus.ack <= 1'b0;  // drops the cycle after req
                        phase   <= PH_IDLE;
                    end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    // byte shifter, out on write and in on read
    always_ff @(posedge CLK)
    begin
        if (phase == PH_IDLE && bus.req && bus.cmd == CMD_WRITE)
            shreg <= bus.tx_byte;
        else if (phase == PH_SHIFT_OUT && bit_end)
            shreg <= {shreg[6:0], 1'b0};
        else if (phase == PH_SHIFT_IN && sample)
            shreg <= {shreg[6:0], sda_in};
    end

endmodule

//--- eeprom_sequencer.sv
`timescale 1ns/1ps
module eeprom_sequencer (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          WR,
    input  logic                          RD,
    input  logic [eeprom_pkg::ADDR_W-1:0] ADDR,
    input  logic [7:0]                    WDATA,
    output logic [7:0]                    RDATA,
    output logic                          ACK,
    output logic                          NACK_ERR,
    byte_shift_if.master                  bus
);
    import eeprom_pkg::*;
    import serial_bus_pkg::*;

    seq_state_e        state;
    seq_state_e        state_next;  // next state after a clean command
    host_op_e          op;
    logic [ADDR_W-1:0] addr_q;
    logic [7:0]        wdata_q;
    logic              host_req;
    logic              cmd_done;
    logic              cmd_idle;

    assign host_req = WR || RD;
    assign cmd_done = bus.req && bus.ack;
    assign cmd_idle = !bus.req && !bus.ack;  // engine back in idle

    // command for the current state
    always_comb
    begin
        bus.cmd     = CMD_START;
        bus.tx_byte = 8'h00;
        state_next  = S_IDLE;
        case (state)
            S_START:
                state_next = S_CTRL_WR;
            S_CTRL_WR:
            begin
                bus.cmd     = CMD_WRITE;
                bus.tx_byte = {DEV_CODE, addr_q[ADDR_W-1:8], 1'b0};
                state_next  = S_ADDR;
            end
            S_ADDR:
            begin
                bus.cmd     = CMD_WRITE;
                bus.tx_byte = addr_q[7:0];
                state_next  = (op == OP_READ) ? S_RESTART : S_DATA;
            end
            S_DATA:
            begin
                bus.cmd     = CMD_WRITE;
                bus.tx_byte = wdata_q;
                state_next  = S_STOP;
            end
            S_RESTART:
                state_next = S_CTRL_RD;
            S_CTRL_RD:
            begin
                bus.cmd     = CMD_WRITE;
                bus.tx_byte = {DEV_CODE, addr_q[ADDR_W-1:8], 1'b1};
                state_next  = S_READ;
            end
            S_READ:
            begin
                bus.cmd    = CMD_READ;  // ends with master nack
                state_next = S_STOP;
            end
            S_STOP:
            begin
                bus.cmd    = CMD_STOP;
                state_next = S_DONE;
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= S_IDLE;
            bus.req  <= 1'b0;
            ACK      <= 1'b0;
            NACK_ERR <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                    if (host_req)
                    begin
                        NACK_ERR <= 1'b0;
                        state    <= S_START;
                    end
                S_START, S_CTRL_WR, S_ADDR, S_DATA, S_RESTART,
                S_CTRL_RD, S_READ, S_STOP:
                begin
                    if (cmd_idle)
                        bus.req <= 1'b1;
                    else if (cmd_done)
                    begin
                        bus.req <= 1'b0;
                        // missing slave ack, skip to stop
                        if (bus.cmd == CMD_WRITE && bus.nack)
                        begin
                            NACK_ERR <= 1'b1;
                            state    <= S_STOP;
                        end
                        else
                            state <= state_next;
                        if (state == S_STOP)
                            ACK <= 1'b1;
                    end
                end
                S_DONE:
                    if (!host_req)
                    begin
                        ACK   <= 1'b0;
                        state <= S_IDLE;
                    end
                default: state <= S_IDLE;
            endcase
        end
    end

    // request capture and read data
    always_ff @(posedge CLK)
    begin
        if (state == S_IDLE && host_req)
        begin
            op      <= RD ? OP_READ : OP_WRITE;
            addr_q  <= ADDR;
            wdata_q <= WDATA;
        end
        if (state == S_READ && cmd_done)
            RDATA <= bus.rx_byte;
    end

endmodule

//--- eeprom_host_top.sv
`timescale 1ns/1ps
module eeprom_host_top #(
    parameter int CLK_DIV = 2
) (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          WR,
    input  logic                          RD,
    input  logic [eeprom_pkg::ADDR_W-1:0] ADDR,
    input  logic [7:0]                    WDATA,
    output logic [7:0]                    RDATA,
    output logic                          ACK,
    output logic                          NACK_ERR,
    output logic                          SCL,
    inout  wire                           SDA
);
    logic sda_out_en;
    logic sda_meta;
    logic sda_sync;

    byte_shift_if bus0 ();

    eeprom_sequencer seq0 (
        .CLK      (CLK),
        .RESET    (RESET),
        .WR       (WR),
        .RD       (RD),
        .ADDR     (ADDR),
        .WDATA    (WDATA),
        .RDATA    (RDATA),
        .ACK      (ACK),
        .NACK_ERR (NACK_ERR),
        .bus      (bus0.master)
    );

    bus_bit_engine #(.CLK_DIV(CLK_DIV)) eng0 (
        .CLK        (CLK),
        .RESET      (RESET),
        .bus        (bus0.engine),
        .SCL        (SCL),
        .sda_in     (sda_sync),
        .sda_out_en (sda_out_en)
    );

    assign SDA = sda_out_en ? 1'b0 : 1'bz;  // open drain, pull-up is external

    // two-flop sync of the bus line
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            sda_meta <= 1'b1;
            sda_sync <= 1'b1;
        end
        else
        begin
            sda_meta <= SDA;
            sda_sync <= sda_meta;
        end
    end

endmodule

//--- tb_eeprom_slave.sv
`timescale 1ns/1ps
module tb_eeprom_slave (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        SCL,
    inout  wire         SDA,
    output logic [15:0] start_cnt
);
    typedef enum logic [2:0] {
        SL_IDLE, SL_CTRL, SL_ADDR, SL_WDATA, SL_RDATA, SL_IGNORE
    } slave_phase_e;

    logic [7:0]   mem [0:2047];
    slave_phase_e phase;
    slave_phase_e phase_after_ack;
    logic         scl_q;
    logic         sda_q;
    logic         sda_now;
    logic         drive_low;
    logic         in_ack;     // inside the ninth clock of a byte
    logic         wr_pending;
    logic [3:0]   cnt;
    logic [7:0]   sr;
    logic [7:0]   tx;
    logic [7:0]   wr_data;
    logic [2:0]   blk;
    logic [10:0]  ptr;

    function automatic logic [7:0] fill_byte(input logic [10:0] a);
        return a[7:0] ^ {a[10:8], 5'b10110};
    endfunction

    assign SDA     = drive_low ? 1'b0 : 1'bz;
    assign sda_now = (SDA !== 1'b0);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            phase      <= SL_IDLE;
            drive_low  <= 1'b0;
            in_ack     <= 1'b0;
            wr_pending <= 1'b0;
            cnt        <= 4'd0;
            start_cnt  <= 16'd0;
            scl_q      <= 1'b1;
            sda_q      <= 1'b1;
            for (int a = 0; a < 2048; a++)
                mem[a] <= fill_byte(11'(a));
        end
        else
        begin
            scl_q <= SCL;
            sda_q <= sda_now;
            if (scl_q && SCL && sda_q && !sda_now)  // start or repeated start
            begin
                start_cnt <= start_cnt + 16'd1;
                phase     <= SL_CTRL;
                cnt       <= 4'd0;
                in_ack    <= 1'b0;
                drive_low <= 1'b0;
            end
            else if (scl_q && SCL && !sda_q && sda_now)  // stop, write commits here
            begin
                if (wr_pending)
                    mem[ptr] <= wr_data;
                wr_pending <= 1'b0;
                phase      <= SL_IDLE;
                in_ack     <= 1'b0;
                drive_low  <= 1'b0;
            end
            else if (SCL && !scl_q && phase != SL_IDLE && phase != SL_IGNORE)
            begin
                if (!in_ack && cnt < 4'd8)
                begin
                    sr  <= {sr[6:0], sda_now};
                    cnt <= cnt + 4'd1;
                end
            end
            else if (!SCL && scl_q && phase != SL_IDLE && phase != SL_IGNORE)
            begin
                if (in_ack)
                begin
                    in_ack    <= 1'b0;
                    drive_low <= 1'b0;
                    phase     <= phase_after_ack;
                    if (phase_after_ack == SL_RDATA)
                    begin
                        tx        <= mem[ptr];
                        drive_low <= ~mem[ptr][7];
                    end
                end
                else if (cnt == 4'd8)
                begin
                    cnt    <= 4'd0;
                    in_ack <= 1'b1;
                    case (phase)
                        SL_CTRL:
                            if (sr[7:4] == 4'b1010)
                            begin
                                drive_low       <= 1'b1;
                                blk             <= sr[3:1];
                                ptr[10:8]       <= sr[3:1];
                                phase_after_ack <= sr[0] ? SL_RDATA : SL_ADDR;
                            end
                            else
                                phase <= SL_IGNORE;
                        SL_ADDR:
                        begin
                            drive_low       <= 1'b1;
                            ptr             <= {blk, sr};
                            phase_after_ack <= SL_WDATA;
                        end
                        SL_WDATA:
                            if (blk != 3'd7)  // top block is write protected
                            begin
                                drive_low       <= 1'b1;
                                wr_data         <= sr;
                                wr_pending      <= 1'b1;
                                phase_after_ack <= SL_IGNORE;
                            end
                            else
                                phase <= SL_IGNORE;
                        default:
                        begin
                            drive_low       <= 1'b0;  // master ack slot
                            phase_after_ack <= SL_IGNORE;
                        end
                    endcase
                end
                else if (phase == SL_RDATA)
                    drive_low <= ~tx[3'(7 - cnt)];
            end
        end
    end

endmodule

//--- tb_eeprom_host.sv
`timescale 1ns/1ps
module tb_eeprom_host;
    import eeprom_pkg::*;

    localparam int CLK_DIV    = 2;
    localparam int N_RANDOM   = 200;
    localparam int N_TRANS    = 2 + N_RANDOM + 2 + 4;
    localparam int MAX_CYCLES = N_TRANS * 100 * CLK_DIV * 4 + 2000;

    logic              CLK;
    logic              RESET;
    logic              WR;
    logic              RD;
    logic [ADDR_W-1:0] ADDR;
    logic [7:0]        WDATA;
    logic [7:0]        RDATA;
    logic              ACK;
    logic              NACK_ERR;
    logic              SCL;
    wire               SDA;
    logic [15:0]       start_cnt;

    logic [7:0]        model [0:2047];  // reference copy of slave memory
    logic [31:0]       lfsr;
    logic [31:0]       rnd;
    host_op_e          op;
    logic [ADDR_W-1:0] addr;
    logic [ADDR_W-1:0] last_wr;
    logic [7:0]        data;
    int                hold;
    int                cycles = 0;
    int                errors;
    int                test_errors;
    int                tests_run;
    int                tests_failed;

    pullup (SDA);

    eeprom_host_top #(.CLK_DIV(CLK_DIV)) dut0 (
        .CLK(CLK), .RESET(RESET), .WR(WR), .RD(RD), .ADDR(ADDR), .WDATA(WDATA),
        .RDATA(RDATA), .ACK(ACK), .NACK_ERR(NACK_ERR), .SCL(SCL), .SDA(SDA)
    );

    tb_eeprom_slave slave0 (
        .CLK(CLK), .RESET(RESET), .SCL(SCL), .SDA(SDA), .start_cnt(start_cnt)
    );

    function automatic logic [7:0] fill_byte(input logic [10:0] a);
        return a[7:0] ^ {a[10:8], 5'b10110};
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic run_op(input host_op_e op_in, input logic [10:0] a, input logic [7:0] d,
                          input int extra);
        logic [15:0] starts0;
        logic        exp_nack;
        int          n_starts;
        @(negedge CLK);
        ADDR     = a;
        WDATA    = d;
        WR       = (op_in == OP_WRITE);
        RD       = (op_in == OP_READ);
        starts0  = start_cnt;
        exp_nack = (op_in == OP_WRITE) && (a[10:8] == 3'd7);
        n_starts = (op_in == OP_READ) ? 2 : 1;
        @(negedge CLK);
        while (!ACK)
            @(negedge CLK);
        assert (NACK_ERR == exp_nack)
        else
        begin
            $display("mismatch at %0t: NACK_ERR %b at addr %h, expected %b",
                     $time, NACK_ERR, a, exp_nack);
            errors++;
        end
        assert (SCL && SDA !== 1'b0)
        else
        begin
            $display("error at %0t: bus not released after the stop", $time);
            errors++;
        end
        assert (16'(start_cnt - starts0) == 16'(n_starts))
        else
        begin
            $display("error at %0t: slave saw %0d start conditions, expected %0d",
                     $time, 16'(start_cnt - starts0), n_starts);
            errors++;
        end
        if (op_in == OP_READ)
        begin
            assert (RDATA == model[a])
            else
            begin
                $display("mismatch at %0t: read addr %h got %h expected %h",
                         $time, a, RDATA, model[a]);
                errors++;
            end
        end
        else if (!exp_nack)
            model[a] = d;
        repeat (extra)
        begin
            @(negedge CLK);
            assert (ACK && start_cnt == 16'(starts0 + n_starts))
            else
            begin
                $display("error at %0t: ACK dropped or a new start came while request held",
                         $time);
                errors++;
            end
        end
        WR = 1'b0;
        RD = 1'b0;
        @(negedge CLK);
        assert (!ACK)
        else
        begin
            $display("error at %0t: ACK still high a cycle after the request dropped", $time);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors > test_errors)
        begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name, errors - test_errors);
        end
        else
            $display("test %0d %s: ok", tests_run, name);
        test_errors = errors;
    endtask

    initial
    begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    initial
    begin
        RESET = 1'b1;
        WR = 1'b0;
        RD = 1'b0;
        ADDR = '0;
        WDATA = 8'h00;
        lfsr = 32'h8406;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        for (int a = 0; a < 2048; a++)
            model[a] = fill_byte(11'(a));
        repeat (16) @(negedge CLK);
        RESET = 1'b0;

        repeat (8)
        begin
            @(negedge CLK);
            assert (!ACK && !NACK_ERR)
            else
            begin
                $display("error at %0t: ACK or NACK_ERR high before any request", $time);
                errors++;
            end
            assert (SCL && SDA !== 1'b0)
            else
            begin
                $display("error at %0t: SCL or SDA low while the bus should be idle", $time);
                errors++;
            end
        end
        report_test("idle after reset");

        run_op(OP_WRITE, 11'h2a5, 8'h5c, 0);
        run_op(OP_READ, 11'h2a5, 8'h00, 0);
        report_test("fixed write and read back");

        last_wr = 11'h2a5;
        for (int i = 0; i < N_RANDOM; i++)
        begin
            take_bits(1, rnd);
            op = host_op_e'(rnd[0]);
            take_bits(8, rnd);
            addr[10:8] = 3'(rnd % 7);  // blocks 0 to 6
            take_bits(8, rnd);
            addr[7:0] = rnd[7:0];
            take_bits(8, rnd);
            data = rnd[7:0];
            take_bits(1, rnd);
            if (op == OP_READ && rnd[0])
                addr = last_wr;        // read back a recent write
            run_op(op, addr, data, 0);
            if (op == OP_WRITE)
                last_wr = addr;
        end
        report_test("random writes and reads");

        take_bits(8, rnd);
        addr = {3'd7, rnd[7:0]};
        data = ~model[addr];           // differs from the protected byte
        run_op(OP_WRITE, addr, data, 0);
        run_op(OP_READ, addr, 8'h00, 0);
        report_test("write protected block");

        for (int i = 0; i < 4; i++)
        begin
            take_bits(4, rnd);
            hold = int'(rnd[3:0]) + 1;
            if (i % 2 == 0)
            begin
                take_bits(8, rnd);
                addr = {3'(rnd % 7), 8'h00};
                take_bits(8, rnd);
                addr[7:0] = rnd[7:0];
                take_bits(8, rnd);
                run_op(OP_WRITE, addr, rnd[7:0], hold);
            end
            else
                run_op(OP_READ, addr, 8'h00, hold);
        end
        report_test("held request handshake");

        $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

//--- all.f
eeprom_pkg.sv
serial_bus_pkg.sv
byte_shift_if.sv
bus_bit_engine.sv
eeprom_sequencer.sv
eeprom_host_top.sv
tb_eeprom_slave.sv
tb_eeprom_host.sv

//--- Makefile
TOP = tb_eeprom_host

all: run

build:
	verilator --binary --timing --assert -j 0 -f all.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$"

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module eeprom_host_top

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
